// File: verilog/pix_pkg.sv
`default_nettype none

package pix_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic [2:0] coord_t; // widen together with ROW_LEN/ROW_COUNT
	typedef logic signed [7:0] coef_t;
	typedef logic [2:0] shift_t;

	localparam int num_taps = 9;

	typedef enum logic [1:0] {idle, row_a, row_b, row_c} row_sel_e;

	typedef struct packed {
		logic a;
		logic b;
		logic c;
	} row_wren_t;

	// one window column, oldest row first
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} pix_col_t;

	typedef struct packed {
		pix_col_t left;
		pix_col_t center;
		pix_col_t right;
	} window_t;

	typedef struct packed {
		coef_t [0:num_taps-1] coef; // raster order
		shift_t shift;
	} kernel_cfg_t;

endpackage

`default_nettype wire

// File: verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

	typedef logic [7:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t resp_okay = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;

	// master side, all five channels
	typedef struct packed {
		axil_addr_t awaddr;
		logic awvalid;
		axil_data_t wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		axil_addr_t araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		axil_resp_t bresp;
		logic bvalid;
		logic arready;
		axil_data_t rdata;
		axil_resp_t rresp;
		logic rvalid;
	} axil_rsp_t;

	localparam axil_addr_t reg_coef_base = 8'h00; // nine words up to 0x20
	localparam axil_addr_t reg_shift = 8'h24;
	localparam axil_addr_t reg_frames = 8'h28; // read only

endpackage

`default_nettype wire

// File: verilog/row_wren_gen.sv
`timescale 1ns/100ps
`default_nettype none

module row_wren_gen #(
	parameter int ROW_LEN = 8,
	parameter int ROW_COUNT = 8
) (
	input wire clk,
	input wire aclr,
	input wire pix_valid,
	output pix_pkg::row_wren_t row_wren,
	output pix_pkg::coord_t wr_col,
	output pix_pkg::coord_t wr_row,
	output logic frame_done
);
	import pix_pkg::*;

	localparam coord_t last_col = coord_t'(ROW_LEN - 1);
	localparam coord_t last_row = coord_t'(ROW_COUNT - 1);

	row_sel_e state;
	coord_t col_cnt; // column of the next accepted pixel
	coord_t row_cnt;
	logic valid_q;
	logic frame_start;

	assign frame_start = (col_cnt == '0) && (row_cnt == '0);

	// state names the row that holds the registered pixel
	always_comb begin
		row_wren = '0;
		if (valid_q) begin
			case (state)
				row_a: row_wren.a = 1'b1;
				row_b: row_wren.b = 1'b1;
				row_c: row_wren.c = 1'b1;
				default: row_wren = '0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			state <= idle;
		end else if (pix_valid) begin
			if (frame_start)
				state <= row_a; // also back to back frames
			else if (col_cnt == '0)
				case (state)
					row_a: state <= row_b;
					row_b: state <= row_c;
					default: state <= row_a;
				endcase
		end else if (frame_start) begin
			state <= idle; // frame written, nothing pending
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			col_cnt <= '0;
			row_cnt <= '0;
			wr_col <= '0;
			wr_row <= '0;
			valid_q <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			valid_q <= pix_valid;
			frame_done <= pix_valid && (col_cnt == last_col) && (row_cnt == last_row);
			if (pix_valid) begin
				wr_col <= col_cnt;
				wr_row <= row_cnt;
				if (col_cnt == last_col) begin
					col_cnt <= '0;
					row_cnt <= (row_cnt == last_row) ? '0 : row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/row_buffers.sv
`timescale 1ns/100ps
`default_nettype none

module row_buffers #(
	parameter int ROW_LEN = 8
) (
	input wire clk,
	input wire aclr,
	input wire pix_valid,
	input wire pix_pkg::pixel_t pix,
	input wire pix_pkg::row_wren_t row_wren,
	input wire pix_pkg::coord_t wr_col,
	output pix_pkg::pix_col_t column
);
	import pix_pkg::*;

	pixel_t ram [3][ROW_LEN]; // rows a, b, c
	pixel_t pix_q;
	logic valid_q;
	logic [1:0] idx_top;
	logic [1:0] idx_mid;

	always_ff @(posedge clk) begin
		if (pix_valid)
			pix_q <= pix;
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr)
			valid_q <= 1'b0;
		else
			valid_q <= pix_valid;
	end

	always_ff @(posedge clk) begin
		if (valid_q) begin
			if (row_wren.a)
				ram[0][wr_col] <= pix_q;
			if (row_wren.b)
				ram[1][wr_col] <= pix_q;
			if (row_wren.c)
				ram[2][wr_col] <= pix_q;
		end
	end

	// the two rows before the newest one, in rotation order
	always_comb begin
		if (row_wren.b) begin
			idx_mid = 2'd0;
			idx_top = 2'd2;
		end else if (row_wren.c) begin
			idx_mid = 2'd1;
			idx_top = 2'd0;
		end else begin
			idx_mid = 2'd2;
			idx_top = 2'd1;
		end
	end

	always_comb begin
		column.top = ram[idx_top][wr_col];
		column.mid = ram[idx_mid][wr_col];
		column.bot = pix_q; // newest row bypasses the ram
	end

endmodule

`default_nettype wire

// File: verilog/window_former.sv
`timescale 1ns/100ps
`default_nettype none

module window_former #(
	parameter int ROW_LEN = 8,
	parameter int ROW_COUNT = 8
) (
	input wire clk,
	input wire aclr,
	input wire write_strobe,
	input wire pix_pkg::coord_t wr_col,
	input wire pix_pkg::coord_t wr_row,
	input wire pix_pkg::pix_col_t column,
	output pix_pkg::window_t win,
	output logic win_valid
);
	import pix_pkg::*;

	localparam coord_t first_full = coord_t'(2); // kernel width minus one

	logic col_inside;
	logic row_inside;

	// window spans wr_col-2 .. wr_col and wr_row-2 .. wr_row
	assign col_inside = (wr_col >= first_full) && (int'(wr_col) < ROW_LEN);
	assign row_inside = (wr_row >= first_full) && (int'(wr_row) < ROW_COUNT);

	always_ff @(posedge clk) begin
		if (write_strobe) begin
			win.left <= win.center;
			win.center <= win.right;
			win.right <= column;
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr)
			win_valid <= 1'b0;
		else
			win_valid <= write_strobe && col_inside && row_inside;
	end

endmodule

`default_nettype wire

// File: verilog/conv_kernel.sv
`timescale 1ns/100ps
`default_nettype none

module conv_kernel (
	input wire clk,
	input wire aclr,
	input wire pix_pkg::window_t win,
	input wire win_valid,
	input wire pix_pkg::kernel_cfg_t cfg,
	output pix_pkg::pixel_t out_pix,
	output logic out_valid
);
	import pix_pkg::*;

	localparam int sum_w = 20; // nine 17 bit products

	pixel_t taps [num_taps];
	logic signed [sum_w-1:0] sum;
	logic signed [sum_w-1:0] shifted;
	pixel_t clamped;

	always_comb begin
		taps = '{win.left.top, win.center.top, win.right.top,
			win.left.mid, win.center.mid, win.right.mid,
			win.left.bot, win.center.bot, win.right.bot};
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < num_taps; i++)
			sum = sum + $signed({1'b0, taps[i]}) * $signed(cfg.coef[i]);
		shifted = sum >>> cfg.shift;
		if (shifted < 0)
			clamped = '0;
		else if (shifted > 255)
			clamped = 8'hff;
		else
			clamped = shifted[7:0];
	end

	always_ff @(posedge clk) begin
		if (win_valid)
			out_pix <= clamped;
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr)
			out_valid <= 1'b0;
		else
			out_valid <= win_valid;
	end

endmodule

`default_nettype wire

// File: verilog/filter_regs.sv
`timescale 1ns/100ps
`default_nettype none

module filter_regs (
	input wire clk,
	input wire aclr,
	input wire axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	input wire frame_done,
	output pix_pkg::kernel_cfg_t cfg
);
	import axil_pkg::*;
	import pix_pkg::*;

	axil_data_t frames;
	axil_data_t rd_data;
	axil_data_t r_data;
	axil_resp_t rd_resp;
	axil_resp_t r_resp;
	axil_resp_t wr_resp;
	axil_resp_t b_resp;
	axil_addr_t wr_off;
	axil_addr_t rd_off;
	logic aw_ready;
	logic b_valid;
	logic ar_ready;
	logic r_valid;
	logic wr_fire;
	logic rd_fire;

	function automatic logic is_coef(input axil_addr_t off);
		return (off[1:0] == 2'b00) && (off[7:2] < num_taps);
	endfunction

	assign wr_off = axil_req.awaddr - reg_coef_base;
	assign rd_off = axil_req.araddr - reg_coef_base;
	assign wr_fire = aw_ready && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = ar_ready && axil_req.arvalid;

	always_comb begin
		axil_rsp.awready = aw_ready;
		axil_rsp.wready = aw_ready; // aw and w taken together
		axil_rsp.bresp = b_resp;
		axil_rsp.bvalid = b_valid;
		axil_rsp.arready = ar_ready;
		axil_rsp.rdata = r_data;
		axil_rsp.rresp = r_resp;
		axil_rsp.rvalid = r_valid;
	end

	assign wr_resp = (is_coef(wr_off) || axil_req.awaddr == reg_shift) ? resp_okay : resp_slverr;

	always_comb begin
		rd_data = '0;
		rd_resp = resp_okay;
		if (is_coef(rd_off))
			rd_data = {24'b0, cfg.coef[rd_off[7:2]]};
		else if (axil_req.araddr == reg_shift)
			rd_data = {29'b0, cfg.shift};
		else if (axil_req.araddr == reg_frames)
			rd_data = frames;
		else
			rd_resp = resp_slverr;
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			aw_ready <= 1'b0;
			b_valid <= 1'b0;
			b_resp <= resp_okay;
		end else begin
			aw_ready <= axil_req.awvalid && axil_req.wvalid && !aw_ready && !b_valid;
			if (wr_fire) begin
				b_valid <= 1'b1;
				b_resp <= wr_resp;
			end else if (axil_req.bready) begin
				b_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			ar_ready <= axil_req.arvalid && !ar_ready && !r_valid;
			if (rd_fire)
				r_valid <= 1'b1;
			else if (axil_req.rready)
				r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_data <= rd_data;
			r_resp <= rd_resp;
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr) begin
			cfg <= '0;
		end else if (wr_fire && axil_req.wstrb[0]) begin
			if (is_coef(wr_off))
				cfg.coef[wr_off[7:2]] <= axil_req.wdata[7:0];
			else if (axil_req.awaddr == reg_shift)
				cfg.shift <= axil_req.wdata[2:0];
		end
	end

	always_ff @(posedge clk or posedge aclr) begin
		if (aclr)
			frames <= '0;
		else if (frame_done)
			frames <= frames + 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/line_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

module line_filter_top #(
	parameter int ROW_LEN = 8,
	parameter int ROW_COUNT = 8
) (
	input wire clk,
	input wire aclr,
	input wire axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	input wire pix_valid,
	input wire pix_pkg::pixel_t pix,
	output logic out_valid,
	output pix_pkg::pixel_t out_pix
);
	import pix_pkg::*;

	kernel_cfg_t cfg;
	row_wren_t row_wren;
	coord_t wr_col;
	coord_t wr_row;
	logic frame_done;
	logic write_strobe;
	pix_col_t column;
	window_t win;
	logic win_valid;

	assign write_strobe = row_wren.a | row_wren.b | row_wren.c;

	filter_regs u_regs (
		.clk(clk),
		.aclr(aclr),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.frame_done(frame_done),
		.cfg(cfg)
	);

	row_wren_gen #(.ROW_LEN(ROW_LEN), .ROW_COUNT(ROW_COUNT)) u_wren (
		.clk(clk),
		.aclr(aclr),
		.pix_valid(pix_valid),
		.row_wren(row_wren),
		.wr_col(wr_col),
		.wr_row(wr_row),
		.frame_done(frame_done)
	);

	row_buffers #(.ROW_LEN(ROW_LEN)) u_rows (
		.clk(clk),
		.aclr(aclr),
		.pix_valid(pix_valid),
		.pix(pix),
		.row_wren(row_wren),
		.wr_col(wr_col),
		.column(column)
	);

	window_former #(.ROW_LEN(ROW_LEN), .ROW_COUNT(ROW_COUNT)) u_window (
		.clk(clk),
		.aclr(aclr),
		.write_strobe(write_strobe),
		.wr_col(wr_col),
		.wr_row(wr_row),
		.column(column),
		.win(win),
		.win_valid(win_valid)
	);

	conv_kernel u_kernel (
		.clk(clk),
		.aclr(aclr),
		.win(win),
		.win_valid(win_valid),
		.cfg(cfg),
		.out_pix(out_pix),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// File: tests/tb_line_filter_tasks.svh
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		output axil_resp_t resp);
	int n;
	@(posedge clk);
	axil_req.awaddr <= addr;
	axil_req.awvalid <= 1'b1;
	axil_req.wdata <= data;
	axil_req.wstrb <= 4'hf;
	axil_req.wvalid <= 1'b1;
	axil_req.bready <= 1'b1;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!(axil_rsp.awready && axil_rsp.wready) && n < wait_limit);
	axil_req.awvalid <= 1'b0;
	axil_req.wvalid <= 1'b0;
	if (!(axil_rsp.awready && axil_rsp.wready))
		report_timeout("awready and wready on a register write");
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!axil_rsp.bvalid && n < wait_limit);
	if (!axil_rsp.bvalid)
		report_timeout("bvalid on a register write");
	resp = axil_rsp.bresp;
	axil_req.bready <= 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output axil_resp_t resp);
	int n;
	@(posedge clk);
	axil_req.araddr <= addr;
	axil_req.arvalid <= 1'b1;
	axil_req.rready <= 1'b1;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!axil_rsp.arready && n < wait_limit);
	axil_req.arvalid <= 1'b0;
	if (!axil_rsp.arready)
		report_timeout("arready on a register read");
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!axil_rsp.rvalid && n < wait_limit);
	if (!axil_rsp.rvalid)
		report_timeout("rvalid on a register read");
	data = axil_rsp.rdata;
	resp = axil_rsp.rresp;
	axil_req.rready <= 1'b0;
endtask

task automatic write_reg(input axil_addr_t addr, input int data, input axil_resp_t exp_resp);
	axil_resp_t resp;
	axil_write(addr, axil_data_t'(data), resp);
	check_value($sformatf("write response at 0x%02h", addr), exp_resp, resp);
endtask

task automatic check_reg(input axil_addr_t addr, input int exp_data,
		input axil_resp_t exp_resp);
	axil_data_t data;
	axil_resp_t resp;
	axil_read(addr, data, resp);
	check_value($sformatf("read response at 0x%02h", addr), exp_resp, resp);
	check_value($sformatf("read data at 0x%02h", addr), exp_data, data);
endtask

task automatic load_kernel();
	for (int i = 0; i < 9; i++)
		write_reg(reg_coef_base + axil_addr_t'(4 * i), coefs[i], resp_okay);
	write_reg(reg_shift, shift, resp_okay);
endtask

// leaves pix_valid high so the next frame can follow at once
task automatic drive_frame(input bit gaps);
	for (int r = 0; r < ROW_COUNT; r++)
		for (int c = 0; c < ROW_LEN; c++) begin
			int gap;
			gap = gaps ? {$random(seed)} % 3 : 0;
			repeat (gap) begin
				@(posedge clk);
				pix_valid <= 1'b0;
				pix <= pixel_t'($random(seed)); // junk while idle
			end
			@(posedge clk);
			pix_valid <= 1'b1;
			pix <= pixel_t'(frame[r][c]);
		end
	frames_sent++;
endtask

task automatic wait_drain();
	int n;
	@(posedge clk);
	pix_valid <= 1'b0;
	n = 0;
	while (exp_q.size() > 0 && n < wait_limit) begin
		@(posedge clk);
		n++;
	end
	if (exp_q.size() > 0) begin
		report_timeout($sformatf("%0d more output pixels", exp_q.size()));
		exp_q.delete();
		due_q.delete();
	end
endtask

// File: tests/tb_line_filter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_line_filter;
	import pix_pkg::*;
	import axil_pkg::*;

	localparam int ROW_LEN = 8;
	localparam int ROW_COUNT = 8;
	localparam int wait_limit = 500; // cycles per wait

	logic clk;
	logic aclr;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic pix_valid;
	pixel_t pix;
	logic out_valid;
	pixel_t out_pix;

	int seed = 12;
	int tests = 0;
	int checks = 0;
	int errors = 0;
	int err_base = 0;
	string test_name = "reset";
	int cycle = 0;
	int accept_cnt = 0; // pixel index within the frame
	int frames_sent = 0;
	int frame [ROW_COUNT][ROW_LEN];
	int coefs [9];
	int shift = 0;
	int clamp_lo;
	int clamp_hi;
	int exp_q [$]; // expected pixels, raster order
	int due_q [$]; // cycle each output is due

	`include "tb_line_filter_tasks.svh"

	line_filter_top #(.ROW_LEN(ROW_LEN), .ROW_COUNT(ROW_COUNT)) UUT (
		.clk(clk),
		.aclr(aclr),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.pix_valid(pix_valid),
		.pix(pix),
		.out_valid(out_valid),
		.out_pix(out_pix)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic start_test(input string name);
		test_name = name;
		err_base = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("%s: %s, %0d errors", test_name, (errors == err_base) ? "ok" : "failed",
			errors - err_base);
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("Mismatch in %s, %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("%s: timed out waiting for %s", test_name, what);
	endtask

	task automatic fill_frame();
		for (int r = 0; r < ROW_COUNT; r++)
			for (int c = 0; c < ROW_LEN; c++)
				frame[r][c] = {$random(seed)} % 256;
	endtask

	task automatic random_kernel();
		for (int i = 0; i < 9; i++)
			coefs[i] = $random(seed) % 16;
		shift = 1 + {$random(seed)} % 4;
	endtask

	// 3x3 weighted sum around (r, c), shifted but not yet clamped
	function automatic int filtered_sum(input int r, input int c);
		int sum;
		sum = 0;
		for (int dr = -1; dr <= 1; dr++)
			for (int dc = -1; dc <= 1; dc++)
				sum += frame[r + dr][c + dc] * coefs[3 * (dr + 1) + dc + 1];
		return sum >>> shift;
	endfunction

	task automatic queue_frame(input bit push);
		int v;
		clamp_lo = 0;
		clamp_hi = 0;
		for (int r = 1; r < ROW_COUNT - 1; r++)
			for (int c = 1; c < ROW_LEN - 1; c++) begin
				v = filtered_sum(r, c);
				if (v < 0) begin
					clamp_lo++;
					v = 0;
				end else if (v > 255) begin
					clamp_hi++;
					v = 255;
				end
				if (push)
					exp_q.push_back(v);
			end
	endtask

	// output check, values and timing
	always @(posedge clk) begin
		int row;
		int col;
		int exp_pix;
		int due;
		cycle++;
		if (!aclr && pix_valid) begin
			row = accept_cnt / ROW_LEN;
			col = accept_cnt % ROW_LEN;
			if (row >= 2 && col >= 2)
				due_q.push_back(cycle + 3); // last pixel of a full window
			accept_cnt = (accept_cnt + 1) % (ROW_LEN * ROW_COUNT);
		end
		if (!aclr && out_valid) begin
			checks++;
			assert (exp_q.size() > 0 && due_q.size() > 0) else begin
				$display("%s: output pixel %0d arrived with none expected", test_name, out_pix);
				errors++;
			end
			if (exp_q.size() > 0 && due_q.size() > 0) begin
				exp_pix = exp_q.pop_front();
				due = due_q.pop_front();
				assert (out_pix == exp_pix) else begin
					$display("Mismatch in %s, output pixel: expected %0d, actual %0d",
						test_name, exp_pix, out_pix);
					errors++;
				end
				assert (cycle == due) else begin
					$display("Mismatch in %s, output cycle: expected %0d, actual %0d",
						test_name, due, cycle);
					errors++;
				end
			end
		end
	end

	initial begin
		int tries;
		aclr = 1'b1;
		axil_req = '0;
		pix_valid = 1'b0;
		pix = '0;
		repeat (10) @(posedge clk);
		aclr <= 1'b0;
		@(posedge clk);

		start_test("register access");
		check_value("control outputs after reset", 0, {out_valid, axil_rsp.awready,
			axil_rsp.wready, axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid});
		check_reg(reg_frames, 0, resp_okay);
		for (int i = 0; i < 9; i++)
			coefs[i] = $random(seed) % 128;
		shift = 1 + {$random(seed)} % 7;
		load_kernel();
		for (int i = 0; i < 9; i++)
			check_reg(reg_coef_base + axil_addr_t'(4 * i), coefs[i] & 255, resp_okay);
		check_reg(reg_shift, shift, resp_okay);
		check_reg(8'h40, 0, resp_slverr); // unmapped
		write_reg(reg_frames, 5, resp_slverr);
		end_test();

		start_test("identity kernel");
		coefs = '{0, 0, 0, 0, 1, 0, 0, 0, 0};
		shift = 0;
		load_kernel();
		fill_frame();
		queue_frame(1'b1);
		drive_frame(1'b0);
		wait_drain();
		end_test();

		start_test("random kernel");
		fill_frame();
		tries = 0;
		clamp_lo = 0;
		clamp_hi = 0;
		while ((clamp_lo == 0 || clamp_hi == 0) && tries < 100) begin
			random_kernel();
			queue_frame(1'b0); // count clamps only
			tries++;
		end
		checks++;
		assert (clamp_lo > 0 && clamp_hi > 0) else begin
			$display("%s: no kernel found that clamps at both 0 and 255", test_name);
			errors++;
		end
		load_kernel();
		queue_frame(1'b1);
		drive_frame(1'b0);
		wait_drain();
		end_test();

		start_test("gapped stream");
		fill_frame();
		queue_frame(1'b1);
		drive_frame(1'b0);
		wait_drain();
		queue_frame(1'b1);
		drive_frame(1'b1);
		wait_drain();
		end_test();

		start_test("frame count");
		for (int f = 0; f < 3; f++) begin
			fill_frame();
			queue_frame(1'b1);
			drive_frame(1'b0); // back to back
		end
		wait_drain();
		check_reg(reg_frames, frames_sent, resp_okay);
		end_test();

		repeat (5) @(posedge clk);
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+tests
verilog/pix_pkg.sv
verilog/axil_pkg.sv
verilog/row_wren_gen.sv
verilog/row_buffers.sv
verilog/window_former.sv
verilog/conv_kernel.sv
verilog/filter_regs.sv
verilog/line_filter_top.sv
tests/tb_line_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the line filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_line_filter \
	-f build.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_line_filter > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASSED" "$sim_log"; then
	exit 0
fi
exit 1
